// File: all.f
+incdir+rtl
rtl/otp_part_pkg.sv
rtl/otp_bus_pkg.sv
rtl/part_ctrl_if.sv
rtl/part_fsm.sv
rtl/part_window.sv
rtl/part_digest_lock.sv
rtl/otp_part_unbuf.sv
dv/otp_mem_model.sv
dv/tb_otp_part_unbuf.sv

// File: dv/otp_mem_model.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Behavioural OTP macro for the partition testbench
// Halfword memory, random grant and response delay
// Error code injection per access
//////////////////////////////////////////////////

`include "otp_part_defs.svh"

module otp_mem_model
  import otp_part_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [`OTP_ADDR_W-1:0] addr_i,
  input  logic [`OTP_SIZE_W-1:0] size_i,
  // Error code returned with the next response
  input  part_err_e              inj_err_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`BLOCK_W-1:0]    rdata_o,
  output part_err_e              err_o
);

  // Halfword storage, preloaded by the testbench
  logic [`OTP_WORD_W-1:0] mem [0:(1 << `OTP_ADDR_W) - 1];

  integer                 seed;
  // Cycles left before the grant, negative when not drawn yet
  integer                 gnt_wait;
  // Cycles left before the response
  integer                 rsp_wait;
  integer                 idx;
  logic                   busy;
  logic [`OTP_ADDR_W-1:0] cmd_addr;
  logic [`OTP_SIZE_W-1:0] cmd_size;
  logic [`BLOCK_W-1:0]    rsp_data;

  initial begin
    seed     = 32'h715f_1998;
    gnt_wait = -1;
    rsp_wait = 0;
    busy     = 1'b0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = NoError;
    forever begin
      @(posedge clk_i or negedge rst_ni);
      if (!rst_ni) begin
        gnt_o    <= 1'b0;
        rvalid_o <= 1'b0;
        rdata_o  <= '0;
        err_o    <= NoError;
        busy     = 1'b0;
        gnt_wait = -1;
        rsp_wait = 0;
      end else begin
        rvalid_o <= 1'b0;
        rdata_o  <= '0;
        err_o    <= NoError;
        if (gnt_o && req_i) begin
          // Command accepted, response 1 to 3 cycles on
          gnt_o    <= 1'b0;
          cmd_addr = addr_i;
          cmd_size = size_i;
          rsp_wait = 1 + ({$random(seed)} % 3);
          busy     = 1'b1;
        end else if (!busy && req_i && !gnt_o) begin
          // Grant after 0 to 3 extra cycles
          if (gnt_wait < 0) begin
            gnt_wait = {$random(seed)} % 4;
          end
          if (gnt_wait == 0) begin
            gnt_o <= 1'b1;
          end
          gnt_wait = gnt_wait - 1;
        end
        if (busy) begin
          rsp_wait = rsp_wait - 1;
          if (rsp_wait == 0) begin
            // Little-endian halfword assembly, size+1 words
            rsp_data = '0;
            for (idx = 0; idx <= cmd_size; idx = idx + 1) begin
              rsp_data[idx*`OTP_WORD_W +: `OTP_WORD_W] = mem[cmd_addr + idx];
            end
            rvalid_o <= 1'b1;
            rdata_o  <= rsp_data;
            err_o    <= inj_err_i;
            busy     = 1'b0;
          end
        end
      end
    end
  end

endmodule

// File: dv/tb_otp_part_unbuf.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Testbench of the unbuffered OTP partition
// Clock, reset and init, stimulus table
// Bus read checks, watchdog
//////////////////////////////////////////////////

`include "otp_part_defs.svh"

module tb_otp_part_unbuf
  import otp_part_pkg::*;
  import otp_bus_pkg::*;
();

  localparam int NumEntries = 14;
  // 100 cycles per table entry plus init and reset slack
  localparam int CycleLimit = 100 * NumEntries + 200;

  // One bus read with its expected response
  typedef struct packed {
    logic [`SW_ADDR_W-1:0] addr;
    mubi8_t                rlock;
    part_err_e             inj;
    logic                  esc;
    logic [1:0]            exp_rerror;
    logic [31:0]           exp_rdata;
    part_err_e             exp_err;
  } entry_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   init_req_i;
  logic                   init_done_o;
  logic                   escalate_i;
  part_err_e              error_o;
  logic                   fsm_err_o;
  part_access_t           access_i;
  part_access_t           access_o;
  logic [`BLOCK_W-1:0]    digest_o;
  logic                   tlul_req_i;
  logic                   tlul_gnt_o;
  logic [`SW_ADDR_W-1:0]  tlul_addr_i;
  logic [1:0]             tlul_rerror_o;
  logic                   tlul_rvalid_o;
  logic [31:0]            tlul_rdata_o;
  logic                   otp_req_o;
  otp_cmd_e               otp_cmd_o;
  logic [`OTP_SIZE_W-1:0] otp_size_o;
  logic [`OTP_ADDR_W-1:0] otp_addr_o;
  logic                   otp_gnt_i;
  logic                   otp_rvalid_i;
  logic [`BLOCK_W-1:0]    otp_rdata_i;
  part_err_e              otp_err_i;
  part_err_e              inj_err;

  entry_t entries [NumEntries];
  int     num_added;
  int     errors;
  int     cycles = 0;
  int     mem_idx;
  int     entry_idx;

  otp_part_unbuf i_otp_part_unbuf (.*);

  otp_mem_model i_otp_mem_model (
    .clk_i,
    .rst_ni,
    .req_i     (otp_req_o),
    .addr_i    (otp_addr_o),
    .size_i    (otp_size_o),
    .inj_err_i (inj_err),
    .gnt_o     (otp_gnt_i),
    .rvalid_o  (otp_rvalid_i),
    .rdata_o   (otp_rdata_i),
    .err_o     (otp_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("** FAIL **");
      $fatal(1, "Watchdog expired");
    end
  end

  //////////////////////////////////////////////////
  // Expected memory content
  //////////////////////////////////////////////////

  // Fill pattern over the full halfword address
  function automatic logic [15:0] halfword_pattern(int unsigned addr);
    logic [9:0] a;
    a = addr[9:0];
    return {a[5:0] ^ 6'h2a, a};
  endfunction

  function automatic logic [31:0] word_pattern(int unsigned word_addr);
    return {halfword_pattern(2 * word_addr + 1), halfword_pattern(2 * word_addr)};
  endfunction

  // Digest block, four halfwords at the digest offset
  function automatic logic [63:0] digest_pattern();
    int unsigned h;
    h = `DIGEST_OFFSET / 2;
    return {halfword_pattern(h + 3), halfword_pattern(h + 2),
            halfword_pattern(h + 1), halfword_pattern(h)};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "Mismatch");
    end
  endtask

  task automatic add_entry(input logic [`SW_ADDR_W-1:0] addr, input mubi8_t rlock,
                           input part_err_e inj, input logic esc,
                           input logic [1:0] exp_rerror, input logic [31:0] exp_rdata,
                           input part_err_e exp_err);
    entries[num_added] = '{addr, rlock, inj, esc, exp_rerror, exp_rdata, exp_err};
    num_added++;
  endtask

  // Partition words 16..27, digest in words 26 and 27
  task automatic build_table();
    add_entry(16, MUBI8_FALSE, NoError, 0, 2'd0, word_pattern(16), NoError);
    add_entry(21, MUBI8_FALSE, NoError, 0, 2'd0, word_pattern(21), NoError);
    add_entry(18, MUBI8_FALSE, MacroEccCorrError, 0, 2'd0, word_pattern(18),
              MacroEccCorrError);
    add_entry(19, MUBI8_FALSE, NoError, 0, 2'd0, word_pattern(19), NoError);
    add_entry(40, MUBI8_FALSE, NoError, 0, 2'd3, 32'h0, AccessError);
    add_entry(17, MUBI8_FALSE, NoError, 0, 2'd0, word_pattern(17), NoError);
    add_entry(15, MUBI8_FALSE, NoError, 0, 2'd3, 32'h0, AccessError);
    add_entry(20, MUBI8_TRUE, NoError, 0, 2'd3, 32'h0, AccessError);
    add_entry(27, MUBI8_FALSE, NoError, 0, 2'd0, word_pattern(27), NoError);
    add_entry(22, MUBI8_FALSE, MacroEccUncorrError, 0, 2'd3, 32'h0, MacroEccUncorrError);
    add_entry(16, MUBI8_FALSE, NoError, 0, 2'd3, 32'h0, MacroEccUncorrError);
    add_entry(23, MUBI8_TRUE, NoError, 0, 2'd3, 32'h0, MacroEccUncorrError);
    // Escalation in a fresh run
    add_entry(24, MUBI8_FALSE, NoError, 1, 2'd3, 32'h0, FsmStateError);
    add_entry(25, MUBI8_FALSE, NoError, 0, 2'd3, 32'h0, FsmStateError);
  endtask

  //////////////////////////////////////////////////
  // Sequences
  //////////////////////////////////////////////////

  // Reset, reset values, init pulse, digest and locks
  task automatic reset_and_init();
    logic [63:0] digest_exp;
    digest_exp = digest_pattern();
    @(posedge clk_i);
    rst_ni     <= 1'b0;
    init_req_i <= 1'b0;
    escalate_i <= 1'b0;
    tlul_req_i <= 1'b0;
    inj_err    <= NoError;
    access_i   <= '{read_lock: MUBI8_FALSE, write_lock: MUBI8_FALSE};
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset otp_req", 0, otp_req_o);
    check_value("reset tlul_gnt", 0, tlul_gnt_o);
    check_value("reset tlul_rvalid", 0, tlul_rvalid_o);
    check_value("reset init_done", 0, init_done_o);
    check_value("reset fsm_err", 0, fsm_err_o);
    check_value("reset digest", 0, digest_o);
    check_value("reset access", {MUBI8_TRUE, MUBI8_TRUE}, access_o);
    check_value("reset error", NoError, error_o);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    init_req_i <= 1'b1;
    @(negedge clk_i);
    // Lock register reloaded once out of reset, still uninitialised
    check_value("access before init", {MUBI8_TRUE, MUBI8_TRUE}, access_o);
    @(posedge clk_i);
    init_req_i <= 1'b0;
    @(negedge clk_i);
    // Digest block request, four halfwords at the digest offset
    check_value("digest otp_req", 1, otp_req_o);
    check_value("digest otp_addr", `DIGEST_OFFSET / 2, otp_addr_o);
    check_value("digest otp_size", 3, otp_size_o);
    while (!init_done_o) @(negedge clk_i);
    check_value("digest value", digest_exp, digest_o);
    check_value("error after init", NoError, error_o);
    @(negedge clk_i);
    // Read lock opens, digest keeps the write lock
    check_value("access after init", {MUBI8_FALSE, MUBI8_TRUE}, access_o);
  endtask

  task automatic apply_entry(input int idx);
    entry_t e;
    int     lat;
    logic   fast;
    e = entries[idx];
    // Rejected reads and reads in Error never reach the macro
    fast = (e.exp_rerror == 2'd3) && (e.inj == NoError);
    if (e.esc) begin
      reset_and_init();
      @(posedge clk_i);
      escalate_i <= 1'b1;
      @(negedge clk_i);
      check_value($sformatf("entry %0d fsm_err pulse", idx), 1, fsm_err_o);
      @(posedge clk_i);
      escalate_i <= 1'b0;
      @(negedge clk_i);
      check_value($sformatf("entry %0d fsm_err release", idx), 0, fsm_err_o);
      check_value($sformatf("entry %0d escalation error", idx), FsmStateError, error_o);
    end
    @(posedge clk_i);
    tlul_req_i         <= 1'b1;
    tlul_addr_i        <= e.addr;
    access_i.read_lock <= e.rlock;
    inj_err            <= e.inj;
    @(negedge clk_i);
    while (!tlul_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    tlul_req_i <= 1'b0;
    lat = 1;
    @(negedge clk_i);
    // Accepted reads ask the macro for two halfwords one cycle after the grant
    check_value($sformatf("entry %0d otp_req", idx), !fast, otp_req_o);
    if (!fast) begin
      check_value($sformatf("entry %0d otp_addr", idx), 2 * e.addr, otp_addr_o);
      check_value($sformatf("entry %0d otp_size", idx), 1, otp_size_o);
    end
    while (!tlul_rvalid_o) begin
      @(negedge clk_i);
      lat++;
    end
    check_value($sformatf("entry %0d rerror", idx), e.exp_rerror, tlul_rerror_o);
    check_value($sformatf("entry %0d rdata", idx), e.exp_rdata, tlul_rdata_o);
    if (fast) begin
      check_value($sformatf("entry %0d error latency", idx), 1, lat);
    end else begin
      check_value($sformatf("entry %0d otp rvalid", idx), 1, otp_rvalid_i);
    end
    @(negedge clk_i);
    check_value($sformatf("entry %0d error_o", idx), e.exp_err, error_o);
  endtask

  initial begin
    rst_ni      = 1'b0;
    init_req_i  = 1'b0;
    escalate_i  = 1'b0;
    access_i    = '{read_lock: MUBI8_FALSE, write_lock: MUBI8_FALSE};
    tlul_req_i  = 1'b0;
    tlul_addr_i = '0;
    inj_err     = NoError;
    errors      = 0;
    num_added   = 0;
    for (mem_idx = 0; mem_idx < (1 << `OTP_ADDR_W); mem_idx++) begin
      i_otp_mem_model.mem[mem_idx] = halfword_pattern(mem_idx);
    end
    build_table();
    reset_and_init();
    check_value("otp command", Read, otp_cmd_o);
    for (entry_idx = 0; entry_idx < num_added; entry_idx++) begin
      apply_entry(entry_idx);
    end
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: rtl/otp_bus_pkg.sv
//////////////////////////////////////////////////
// OTP macro command and access control types
// Multi-bit lock values and partition access struct
//////////////////////////////////////////////////

package otp_bus_pkg;

  // OTP macro commands
  typedef enum logic [1:0] {
    Read    = 2'b00,
    Write   = 2'b01,
    ReadRaw = 2'b10,
    Init    = 2'b11
  } otp_cmd_e;

  // Redundantly encoded lock value
  typedef logic [7:0] mubi8_t;

  localparam mubi8_t MUBI8_TRUE  = 8'h96;
  localparam mubi8_t MUBI8_FALSE = 8'h69;

  // Read and write lock of one partition, 16 bits
  typedef struct packed {
    mubi8_t read_lock;
    mubi8_t write_lock;
  } part_access_t;

  // Anything but the exact false pattern counts as locked
  function automatic logic mubi8_test_true_loose(mubi8_t val);
    return val != MUBI8_FALSE;
  endfunction

endpackage

// File: rtl/otp_part_defs.svh
//////////////////////////////////////////////////
// Shared widths and address map of the unbuffered
// OTP partition and its macro interface
//////////////////////////////////////////////////

`ifndef OTP_PART_DEFS_SVH
`define OTP_PART_DEFS_SVH

// OTP macro word and digest block
`define OTP_WORD_W    16
`define BLOCK_W       64

// Address widths, byte and halfword view of the macro
`define BYTE_ADDR_W   11
`define OTP_ADDR_W    10

// Software window addresses 32-bit words
`define SW_ADDR_W     9

// Size field counts macro words minus one
`define OTP_SIZE_W    2

// Partition placement in bytes
`define PART_OFFSET   64
`define PART_SIZE     48

// Digest sits in the last 8 bytes of the partition
`define DIGEST_OFFSET 104

`endif

// File: rtl/otp_part_pkg.sv
//////////////////////////////////////////////////
// Partition level types
// FSM state encoding, error codes, address select
//////////////////////////////////////////////////

package otp_part_pkg;

  // Sparse state codes, minimum Hamming distance 5
  typedef enum logic [9:0] {
    ResetSt    = 10'b1010110110,
    InitSt     = 10'b0100010011,
    InitWaitSt = 10'b0001011000,
    IdleSt     = 10'b1011101001,
    ReadSt     = 10'b0101101110,
    ReadWaitSt = 10'b0110100101,
    ErrorSt    = 10'b1111011111
  } part_state_e;

  // Error codes, shared with the OTP macro response
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h5,
    FsmStateError       = 3'h7
  } part_err_e;

  // OTP address source
  typedef enum logic {
    DigestAddrSel = 1'b0,
    DataAddrSel   = 1'b1
  } addr_sel_e;

endpackage

// File: rtl/otp_part_unbuf.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Unbuffered OTP partition top level
// FSM, window datapath, digest/lock register
//////////////////////////////////////////////////

`include "otp_part_defs.svh"

module otp_part_unbuf
  import otp_part_pkg::*;
  import otp_bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Init handshake
  input  logic                   init_req_i,
  output logic                   init_done_o,
  // Escalation and error status
  input  logic                   escalate_i,
  output part_err_e              error_o,
  output logic                   fsm_err_o,
  // Access control and digest
  input  part_access_t           access_i,
  output part_access_t           access_o,
  output logic [`BLOCK_W-1:0]    digest_o,
  // Software window bus
  input  logic                   tlul_req_i,
  output logic                   tlul_gnt_o,
  input  logic [`SW_ADDR_W-1:0]  tlul_addr_i,
  output logic [1:0]             tlul_rerror_o,
  output logic                   tlul_rvalid_o,
  output logic [31:0]            tlul_rdata_o,
  // OTP macro
  output logic                   otp_req_o,
  output otp_cmd_e               otp_cmd_o,
  output logic [`OTP_SIZE_W-1:0] otp_size_o,
  output logic [`OTP_ADDR_W-1:0] otp_addr_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  logic [`BLOCK_W-1:0]    otp_rdata_i,
  input  part_err_e              otp_err_i
);

  part_ctrl_if ctrl_if ();

  logic         addr_in_range;
  part_access_t access_q;

  // Partition only ever reads
  assign otp_cmd_o = Read;

  assign tlul_rvalid_o = ctrl_if.rsp_valid;
  assign init_done_o   = ctrl_if.init_done;
  assign access_o      = access_q;

  part_fsm i_part_fsm (
    .clk_i,
    .rst_ni,
    .init_req_i,
    .escalate_i,
    .otp_gnt_i,
    .otp_rvalid_i,
    .otp_err_i,
    .tlul_req_i,
    .addr_in_range_i (addr_in_range),
    .access_i        (access_q),
    .otp_req_o,
    .tlul_gnt_o,
    .fsm_err_o,
    .error_o,
    .ctrl            (ctrl_if.fsm_mp)
  );

  part_window i_part_window (
    .clk_i,
    .rst_ni,
    .tlul_addr_i,
    .otp_rdata_i,
    .ctrl            (ctrl_if.window_mp),
    .addr_in_range_o (addr_in_range),
    .otp_addr_o,
    .otp_size_o,
    .tlul_rdata_o,
    .tlul_rerror_o
  );

  part_digest_lock i_part_digest_lock (
    .clk_i,
    .rst_ni,
    .otp_rdata_i,
    .access_i,
    .ctrl     (ctrl_if.digest_mp),
    .digest_o,
    .access_o (access_q)
  );

endmodule

// File: rtl/part_ctrl_if.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Per-cycle commands from the partition FSM
// to the window and digest/lock modules
//////////////////////////////////////////////////

interface part_ctrl_if
  import otp_part_pkg::*;
();

  // Bus grant, latches the window address
  logic      addr_capture;
  // Digest or data address toward the macro
  addr_sel_e addr_sel;
  // Bus response strobe and its error flag
  logic      rsp_valid;
  logic      rsp_err;
  // Load strobe for the digest register
  logic      digest_we;
  // Partition has read its digest and serves reads
  logic      init_done;

  modport fsm_mp (output addr_capture, addr_sel, rsp_valid, rsp_err, digest_we, init_done);

  modport window_mp (input addr_capture, addr_sel, rsp_valid, rsp_err);

  modport digest_mp (input digest_we, init_done);

endinterface

// File: rtl/part_digest_lock.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Digest register of the partition
// Registered read and write lock aggregation
//////////////////////////////////////////////////

`include "otp_part_defs.svh"

module part_digest_lock
  import otp_bus_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`BLOCK_W-1:0] otp_rdata_i,
  // Runtime locks from the CSRs
  input  part_access_t        access_i,
  part_ctrl_if.digest_mp      ctrl,
  output logic [`BLOCK_W-1:0] digest_o,
  output part_access_t        access_o
);

  logic [`BLOCK_W-1:0] digest_q;
  part_access_t        access_d, access_q;
  logic                uninit;
  logic                digest_set;

  //////////////////////////////////////////////////
  // Digest
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (ctrl.digest_we) begin
      digest_q <= otp_rdata_i;
    end
  end

  assign digest_o = digest_q;

  //////////////////////////////////////////////////
  // Locks
  //////////////////////////////////////////////////

  // Uninitialised partition is fully locked
  assign uninit     = !ctrl.init_done;
  // Any nonzero digest seals the partition for writes
  assign digest_set = digest_q != '0;

  always_comb begin
    access_d.read_lock = MUBI8_FALSE;
    access_d.write_lock = MUBI8_FALSE;
    if (uninit || mubi8_test_true_loose(access_i.read_lock)) begin
      access_d.read_lock = MUBI8_TRUE;
    end
    if (uninit || digest_set || mubi8_test_true_loose(access_i.write_lock)) begin
      access_d.write_lock = MUBI8_TRUE;
    end
  end

  // Locks come up true out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= '{read_lock: MUBI8_TRUE, write_lock: MUBI8_TRUE};
    end else begin
      access_q <= access_d;
    end
  end

  assign access_o = access_q;

  // Stored digest write-locks the partition one cycle on
  a_digest_write_lock: assert property (@(posedge clk_i) disable iff (!rst_ni)
    digest_o != '0 |=> mubi8_test_true_loose(access_o.write_lock));

endmodule

// File: rtl/part_fsm.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Partition FSM of the unbuffered OTP partition
// Error register, pending bus error flag
// Escalation and illegal state handling
//////////////////////////////////////////////////

module part_fsm
  import otp_part_pkg::*;
  import otp_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Init pulse, once after reset
  input  logic         init_req_i,
  // Escalation, active high
  input  logic         escalate_i,
  // OTP macro handshake
  input  logic         otp_gnt_i,
  input  logic         otp_rvalid_i,
  input  part_err_e    otp_err_i,
  // Bus request
  input  logic         tlul_req_i,
  // Status from window and lock modules
  input  logic         addr_in_range_i,
  input  part_access_t access_i,
  output logic         otp_req_o,
  output logic         tlul_gnt_o,
  output logic         fsm_err_o,
  output part_err_e    error_o,
  part_ctrl_if.fsm_mp  ctrl
);

  part_state_e state_d, state_q;
  part_err_e   error_d, error_q;
  // Set on a grant in ErrorSt, answered the next cycle
  logic        pend_err_d, pend_err_q;
  addr_sel_e   addr_sel;
  logic        rsp_valid;
  logic        rsp_err;
  logic        digest_we;
  logic        init_done;
  logic        otp_ok;
  logic        read_allowed;

  // Clean or correctable response keeps the partition alive
  assign otp_ok = otp_err_i inside {NoError, MacroEccCorrError};

  // Read lock must hold the exact false pattern
  assign read_allowed = addr_in_range_i && (access_i.read_lock == MUBI8_FALSE);

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    error_d    = error_q;
    pend_err_d = 1'b0;
    otp_req_o  = 1'b0;
    tlul_gnt_o = 1'b0;
    fsm_err_o  = 1'b0;
    addr_sel   = DigestAddrSel;
    rsp_valid  = 1'b0;
    rsp_err    = 1'b0;
    digest_we  = 1'b0;
    init_done  = 1'b0;

    case (state_q)
      // Wait for the init pulse
      ResetSt: begin
        if (init_req_i) begin
          state_d = InitSt;
        end
      end
      // Request the digest block, hold until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Load the digest, anything worse than a corrected ECC error is fatal
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          digest_we = 1'b1;
          if (otp_ok) begin
            state_d = IdleSt;
            if (otp_err_i == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      // Grant bus reads, a new request clears soft errors
      IdleSt: begin
        init_done = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          error_d    = NoError;
          state_d    = ReadSt;
        end
      end
      // Range and lock check on the latched address
      ReadSt: begin
        init_done = 1'b1;
        if (read_allowed) begin
          otp_req_o = 1'b1;
          addr_sel  = DataAddrSel;
          if (otp_gnt_i) begin
            state_d = ReadWaitSt;
          end
        end else begin
          // Bus error, partition stays operational
          state_d   = IdleSt;
          error_d   = AccessError;
          rsp_valid = 1'b1;
          rsp_err   = 1'b1;
        end
      end
      // Forward the macro response to the bus
      ReadWaitSt: begin
        init_done = 1'b1;
        if (otp_rvalid_i) begin
          rsp_valid = 1'b1;
          if (otp_ok) begin
            state_d = IdleSt;
            if (otp_err_i == MacroEccCorrError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
            rsp_err = 1'b1;
          end
        end
      end
      // Terminal state, every request gets a bus error
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        if (pend_err_q) begin
          rsp_valid = 1'b1;
          rsp_err   = 1'b1;
        end else if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          pend_err_d = 1'b1;
        end
      end
      // Glitched state code
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end
  end

  assign error_o           = error_q;
  assign ctrl.addr_capture = tlul_gnt_o;
  assign ctrl.addr_sel     = addr_sel;
  assign ctrl.rsp_valid    = rsp_valid;
  assign ctrl.rsp_err      = rsp_err;
  assign ctrl.digest_we    = digest_we;
  assign ctrl.init_done    = init_done;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ResetSt;
      error_q    <= NoError;
      pend_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      pend_err_q <= pend_err_d;
    end
  end

  // State register only ever holds one of the seven codes
  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {ResetSt, InitSt, InitWaitSt, IdleSt, ReadSt, ReadWaitSt, ErrorSt});

  // Uncorrectable macro error is terminal on the next cycle
  a_uncorr_to_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {InitWaitSt, ReadWaitSt} && otp_rvalid_i && !escalate_i &&
    otp_err_i == MacroEccUncorrError
    |=> state_q == ErrorSt && error_o == MacroEccUncorrError);

endmodule

// File: rtl/part_window.sv
`timescale 1ns/10ps
//////////////////////////////////////////////////
// Software window datapath
// Address capture, range check, OTP address/size
// Read data and bus error gating
//////////////////////////////////////////////////

`include "otp_part_defs.svh"

module part_window
  import otp_part_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`SW_ADDR_W-1:0]  tlul_addr_i,
  input  logic [`BLOCK_W-1:0]    otp_rdata_i,
  part_ctrl_if.window_mp         ctrl,
  output logic                   addr_in_range_o,
  output logic [`OTP_ADDR_W-1:0] otp_addr_o,
  output logic [`OTP_SIZE_W-1:0] otp_size_o,
  output logic [31:0]            tlul_rdata_o,
  output logic [1:0]             tlul_rerror_o
);

  // Partition bounds, one extra bit so the end does not wrap
  localparam logic [`BYTE_ADDR_W:0] PartStart = (`BYTE_ADDR_W+1)'(`PART_OFFSET);
  localparam logic [`BYTE_ADDR_W:0] PartEnd   = (`BYTE_ADDR_W+1)'(`PART_OFFSET + `PART_SIZE);
  localparam logic [`BYTE_ADDR_W-1:0] DigestAddr = `BYTE_ADDR_W'(`DIGEST_OFFSET);

  // Digest is four halfwords, a bus word two
  localparam logic [`OTP_SIZE_W-1:0] DigestSize = `OTP_SIZE_W'(`BLOCK_W / `OTP_WORD_W - 1);
  localparam logic [`OTP_SIZE_W-1:0] WordSize   = `OTP_SIZE_W'(32 / `OTP_WORD_W - 1);

  logic [`SW_ADDR_W-1:0]   addr_q;
  logic [`BYTE_ADDR_W-1:0] byte_addr;
  logic [`BYTE_ADDR_W-1:0] addr_calc;

  // Word address latched on the bus grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (ctrl.addr_capture) begin
      addr_q <= tlul_addr_i;
    end
  end

  assign byte_addr = {addr_q, 2'b00};

  assign addr_in_range_o = ({1'b0, byte_addr} >= PartStart) &&
                           ({1'b0, byte_addr} < PartEnd);

  // Macro works on halfwords, drop the byte bit
  assign addr_calc  = (ctrl.addr_sel == DigestAddrSel) ? DigestAddr : byte_addr;
  assign otp_addr_o = addr_calc[`BYTE_ADDR_W-1 -: `OTP_ADDR_W];
  assign otp_size_o = (ctrl.addr_sel == DigestAddrSel) ? DigestSize : WordSize;

  // Data only leaves on a clean response
  assign tlul_rdata_o  = (ctrl.rsp_valid && !ctrl.rsp_err) ? otp_rdata_i[31:0] : '0;
  assign tlul_rerror_o = {2{ctrl.rsp_err}};

  // Error flag only comes with a response, which then carries no macro data
  a_err_no_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl.rsp_err |-> ctrl.rsp_valid && tlul_rdata_o == '0);

endmodule
